// File: rmii_pkg.sv
package rmii_pkg;

    ////////////////////////////////////////
    // RMII line side
    ////////////////////////////////////////

    localparam int DIBIT_W = 2;
    localparam int BYTE_W = 8;
    localparam int DIBITS_PER_BYTE = BYTE_W / DIBIT_W;

    // Preamble dibits are all 01 until the delimiter ends on 11
    localparam logic [BYTE_W-1:0] SFD_BYTE = 8'hD5;

endpackage

// File: frame_pkg.sv
package frame_pkg;

    ////////////////////////////////////////
    // Frame buffer word
    ////////////////////////////////////////

    localparam int FRAME_WORD_W = rmii_pkg::BYTE_W + 1;

    // Marker flag picks the view
    typedef union packed {
        struct packed {
            logic                           marker;
            logic [rmii_pkg::BYTE_W-1:0]    value;
        } byte_view;
        struct packed {
            logic                           marker;
            logic [rmii_pkg::BYTE_W-2:0]    reserved;
            logic                           error;
        } marker_view;
    } frame_word_t;

    localparam int FRAME_DEPTH = 2048;
    localparam int PAYLOAD_DEPTH = 2048;

    ////////////////////////////////////////
    // Ethernet CRC-32, reflected
    ////////////////////////////////////////

    localparam int CRC_W = 32;
    localparam logic [CRC_W-1:0] CRC_POLY = 32'hEDB88320;
    localparam logic [CRC_W-1:0] CRC_INIT = '1;
    localparam logic [CRC_W-1:0] CRC_RESIDUE = 32'hDEBB20E3;

endpackage

// File: rmii_byte_packager.sv
`timescale 1ns/100ps

module rmii_byte_packager (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic [rmii_pkg::DIBIT_W-1:0]    rmii_rxd,
    input  logic                            rmii_crs_dv,
    input  logic                            rmii_rx_er,
    input  logic                            full,
    output frame_pkg::frame_word_t          word,
    output logic                            push
);

    logic [rmii_pkg::BYTE_W-1:0]                    shifter;
    logic [rmii_pkg::BYTE_W-1:0]                    shifted;
    logic [$clog2(rmii_pkg::DIBITS_PER_BYTE)-1:0]   dibit_count;
    logic                                           in_frame;
    logic                                           frame_error;
    logic                                           error_next;

    // First dibit on the line is the least significant pair
    assign shifted = {rmii_rxd, shifter[rmii_pkg::BYTE_W-1:rmii_pkg::DIBIT_W]};

    // A byte refused by a full buffer this cycle still counts
    assign error_next = frame_error | rmii_rx_er | (push & full);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            shifter     <= '0;
            dibit_count <= '0;
            in_frame    <= 1'b0;
            frame_error <= 1'b0;
            push        <= 1'b0;
        end else begin
            push <= 1'b0;
            if (!rmii_crs_dv) begin
                shifter <= '0;
                if (in_frame) begin
                    push     <= 1'b1;
                    in_frame <= 1'b0;
                end
            end else if (!in_frame) begin
                shifter <= shifted;
                if (shifted == rmii_pkg::SFD_BYTE) begin
                    in_frame    <= 1'b1;
                    dibit_count <= '0;
                    frame_error <= 1'b0;
                end
            end else begin
                shifter     <= shifted;
                dibit_count <= dibit_count + 1'b1;
                frame_error <= error_next;
                if (&dibit_count) begin
                    push <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rmii_crs_dv) begin
            word.marker_view.marker   <= 1'b1;
            word.marker_view.reserved <= '0;
            word.marker_view.error    <= error_next;
        end else begin
            word.byte_view.marker <= 1'b0;
            word.byte_view.value  <= shifted;
        end
    end

endmodule

// File: synchronous_fifo.sv
`timescale 1ns/100ps

module synchronous_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                flush,
    input  logic [WIDTH-1:0]    wr_data,
    input  logic                wr_en,
    output logic                full,
    output logic [WIDTH-1:0]    rd_data,
    output logic                rd_valid,
    input  logic                rd_ready
);

    localparam int ADDR_W = $clog2(DEPTH);

    logic [WIDTH-1:0]   mem [DEPTH];
    logic [ADDR_W:0]    wr_ptr;
    logic [ADDR_W:0]    rd_ptr;
    logic               do_write;
    logic               do_read;

    // Extra pointer bit tells full from empty
    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W])
        && (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign rd_valid = (wr_ptr != rd_ptr);
    assign do_write = wr_en & ~full;
    assign do_read  = rd_valid & rd_ready;

    // Head word shows without a read request
    assign rd_data = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
        end
    end

endmodule

// File: ethernet_packet_parser.sv
`timescale 1ns/100ps

module ethernet_packet_parser (
    input  logic                            clock,
    input  logic                            arst_n,
    input  frame_pkg::frame_word_t          rd_data,
    input  logic                            rd_valid,
    output logic                            rd_ready,
    input  logic                            slot_free,
    output logic [rmii_pkg::BYTE_W-1:0]     wr_data,
    output logic                            wr_en,
    output logic                            frame_good,
    output logic                            frame_bad
);

    logic [frame_pkg::CRC_W-1:0]                crc;
    logic [$clog2(frame_pkg::PAYLOAD_DEPTH):0]  byte_count;
    logic                                       in_frame;
    logic                                       overflow;
    logic                                       take;
    logic                                       verdict_ok;

    function automatic logic [frame_pkg::CRC_W-1:0] crc_update(
        input logic [frame_pkg::CRC_W-1:0] crc_in,
        input logic [rmii_pkg::BYTE_W-1:0] data
    );
        logic [frame_pkg::CRC_W-1:0] c;
        c = crc_in ^ {{(frame_pkg::CRC_W - rmii_pkg::BYTE_W){1'b0}}, data};
        for (int i = 0; i < rmii_pkg::BYTE_W; i++) begin
            c = (c >> 1) ^ (frame_pkg::CRC_POLY & {frame_pkg::CRC_W{c[0]}});
        end
        return c;
    endfunction

    // Start only on a free slot, then run to the marker
    assign rd_ready = (in_frame | slot_free) & ~frame_good & ~frame_bad;
    assign take     = rd_valid & rd_ready;

    assign verdict_ok = (crc == frame_pkg::CRC_RESIDUE)
        & ~rd_data.marker_view.error & ~overflow;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            crc        <= frame_pkg::CRC_INIT;
            byte_count <= '0;
            in_frame   <= 1'b0;
            overflow   <= 1'b0;
            wr_en      <= 1'b0;
            frame_good <= 1'b0;
            frame_bad  <= 1'b0;
        end else begin
            wr_en      <= 1'b0;
            frame_good <= 1'b0;
            frame_bad  <= 1'b0;
            if (take && rd_data.byte_view.marker) begin
                frame_good <= verdict_ok;
                frame_bad  <= ~verdict_ok;
                crc        <= frame_pkg::CRC_INIT;
                byte_count <= '0;
                in_frame   <= 1'b0;
                overflow   <= 1'b0;
            end else if (take) begin
                in_frame <= 1'b1;
                crc      <= crc_update(crc, rd_data.byte_view.value);
                // Top count bit set means the payload buffer is full
                if (!byte_count[$high(byte_count)]) begin
                    wr_en      <= 1'b1;
                    byte_count <= byte_count + 1'b1;
                end else begin
                    overflow <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            wr_data <= rd_data.byte_view.value;
        end
    end

endmodule

// File: receive_slot_handler.sv
`timescale 1ns/100ps

module receive_slot_handler (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            frame_good,
    input  logic                            frame_bad,
    input  logic [rmii_pkg::BYTE_W-1:0]     rd_data,
    input  logic                            rd_valid,
    output logic                            rd_ready,
    output logic                            flush,
    output logic                            slot_free,
    output logic [rmii_pkg::BYTE_W-1:0]     receive_data,
    output logic                            receive_valid,
    output logic                            receive_last,
    input  logic                            receive_ready
);

    // Idle when neither flag is set
    logic draining;
    logic flushing;
    logic load;

    assign rd_ready  = draining & (~receive_valid | receive_ready);
    assign load      = rd_ready & rd_valid;
    assign flush     = flushing;
    assign slot_free = ~draining & ~flushing & ~rd_valid;

    // Parser is held off while draining, so an empty buffer means final byte
    assign receive_last = receive_valid & draining & ~rd_valid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            draining      <= 1'b0;
            flushing      <= 1'b0;
            receive_valid <= 1'b0;
        end else begin
            flushing <= frame_bad;
            if (frame_good) begin
                draining <= 1'b1;
            end else if (draining && !rd_valid && (!receive_valid || receive_ready)) begin
                draining <= 1'b0;
            end
            if (load) begin
                receive_valid <= 1'b1;
            end else if (receive_ready) begin
                receive_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            receive_data <= rd_data;
        end
    end

endmodule

// File: rmii_byte_shipper.sv
`timescale 1ns/100ps

module rmii_byte_shipper (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic [rmii_pkg::BYTE_W-1:0]     transmit_data,
    input  logic                            transmit_valid,
    input  logic                            transmit_last,
    output logic                            transmit_ready,
    output logic [rmii_pkg::DIBIT_W-1:0]    rmii_txd,
    output logic                            rmii_tx_en
);

    logic [rmii_pkg::BYTE_W-1:0]                    shifter;
    logic [$clog2(rmii_pkg::DIBITS_PER_BYTE)-1:0]   dibit_count;
    logic                                           last_byte;
    logic                                           take;

    // Next byte loads while the final dibit of the current one is out
    assign transmit_ready = ~rmii_tx_en | ((&dibit_count) & ~last_byte);
    assign take           = transmit_valid & transmit_ready;

    assign rmii_txd = rmii_tx_en ? shifter[rmii_pkg::DIBIT_W-1:0] : '0;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rmii_tx_en  <= 1'b0;
            dibit_count <= '0;
            last_byte   <= 1'b0;
        end else if (take) begin
            rmii_tx_en  <= 1'b1;
            dibit_count <= '0;
            last_byte   <= transmit_last;
        end else if (rmii_tx_en) begin
            dibit_count <= dibit_count + 1'b1;
            if (&dibit_count) begin
                rmii_tx_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            shifter <= transmit_data;
        end else begin
            shifter <= shifter >> rmii_pkg::DIBIT_W;
        end
    end

endmodule

// File: rmii_port.sv
`timescale 1ns/100ps

module rmii_port (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic [rmii_pkg::DIBIT_W-1:0]    rmii_rxd,
    input  logic                            rmii_crs_dv,
    input  logic                            rmii_rx_er,
    output logic [rmii_pkg::DIBIT_W-1:0]    rmii_txd,
    output logic                            rmii_tx_en,
    output logic [rmii_pkg::BYTE_W-1:0]     receive_data,
    output logic                            receive_valid,
    output logic                            receive_last,
    input  logic                            receive_ready,
    input  logic [rmii_pkg::BYTE_W-1:0]     transmit_data,
    input  logic                            transmit_valid,
    input  logic                            transmit_last,
    output logic                            transmit_ready
);

    frame_pkg::frame_word_t             packed_word;
    logic                               packed_push;
    logic                               frame_full;
    frame_pkg::frame_word_t             frame_word;
    logic                               frame_valid;
    logic                               frame_ready;
    logic [rmii_pkg::BYTE_W-1:0]        payload_wr_data;
    logic                               payload_wr_en;
    logic [rmii_pkg::BYTE_W-1:0]        payload_rd_data;
    logic                               payload_rd_valid;
    logic                               payload_rd_ready;
    logic                               payload_flush;
    logic                               slot_free;
    logic                               frame_good;
    logic                               frame_bad;

    ////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////

    rmii_byte_packager rmii_byte_packager (
        .clock          (clock),
        .arst_n         (arst_n),
        .rmii_rxd       (rmii_rxd),
        .rmii_crs_dv    (rmii_crs_dv),
        .rmii_rx_er     (rmii_rx_er),
        .full           (frame_full),
        .word           (packed_word),
        .push           (packed_push)
    );

    synchronous_fifo #(
        .WIDTH  (frame_pkg::FRAME_WORD_W),
        .DEPTH  (frame_pkg::FRAME_DEPTH)
    ) frame_fifo (
        .clock      (clock),
        .arst_n     (arst_n),
        .flush      (1'b0),
        .wr_data    (packed_word),
        .wr_en      (packed_push),
        .full       (frame_full),
        .rd_data    (frame_word),
        .rd_valid   (frame_valid),
        .rd_ready   (frame_ready)
    );

    ethernet_packet_parser ethernet_packet_parser (
        .clock      (clock),
        .arst_n     (arst_n),
        .rd_data    (frame_word),
        .rd_valid   (frame_valid),
        .rd_ready   (frame_ready),
        .slot_free  (slot_free),
        .wr_data    (payload_wr_data),
        .wr_en      (payload_wr_en),
        .frame_good (frame_good),
        .frame_bad  (frame_bad)
    );

    // One frame at a time, so full is never reached
    synchronous_fifo #(
        .WIDTH  (rmii_pkg::BYTE_W),
        .DEPTH  (frame_pkg::PAYLOAD_DEPTH)
    ) payload_fifo (
        .clock      (clock),
        .arst_n     (arst_n),
        .flush      (payload_flush),
        .wr_data    (payload_wr_data),
        .wr_en      (payload_wr_en),
        .full       (),
        .rd_data    (payload_rd_data),
        .rd_valid   (payload_rd_valid),
        .rd_ready   (payload_rd_ready)
    );

    receive_slot_handler receive_slot_handler (
        .clock          (clock),
        .arst_n         (arst_n),
        .frame_good     (frame_good),
        .frame_bad      (frame_bad),
        .rd_data        (payload_rd_data),
        .rd_valid       (payload_rd_valid),
        .rd_ready       (payload_rd_ready),
        .flush          (payload_flush),
        .slot_free      (slot_free),
        .receive_data   (receive_data),
        .receive_valid  (receive_valid),
        .receive_last   (receive_last),
        .receive_ready  (receive_ready)
    );

    ////////////////////////////////////////
    // Transmit path
    ////////////////////////////////////////

    rmii_byte_shipper rmii_byte_shipper (
        .clock          (clock),
        .arst_n         (arst_n),
        .transmit_data  (transmit_data),
        .transmit_valid (transmit_valid),
        .transmit_last  (transmit_last),
        .transmit_ready (transmit_ready),
        .rmii_txd       (rmii_txd),
        .rmii_tx_en     (rmii_tx_en)
    );

endmodule

// File: rmii_port_chk.sv
`timescale 1ns/100ps

module rmii_port_chk (
    input  logic        clock,
    input  logic        arst_n,
    input  logic [7:0]  receive_data,
    input  logic        receive_valid,
    input  logic        receive_last,
    input  logic        receive_ready,
    input  logic [7:0]  transmit_data,
    input  logic        transmit_valid,
    input  logic        transmit_last,
    input  logic        transmit_ready,
    input  logic        rmii_tx_en
);

    int failures = 0;

    // Receive stream holds while stalled
    receive_hold: assert property (@(posedge clock) disable iff (!arst_n)
        receive_valid && !receive_ready
        |=> receive_valid && $stable(receive_data) && $stable(receive_last))
        else begin
            $error("receive_valid, receive_data or receive_last changed while stalled");
            failures++;
        end

    transmit_hold: assert property (@(posedge clock) disable iff (!arst_n)
        transmit_valid && !transmit_ready
        |=> transmit_valid && $stable(transmit_data) && $stable(transmit_last))
        else begin
            $error("transmit_valid, transmit_data or transmit_last changed while stalled");
            failures++;
        end

    // Outputs quiet during reset
    quiet_in_reset: assert property (@(posedge clock)
        !arst_n |-> !receive_valid && !rmii_tx_en)
        else begin
            $error("receive_valid or rmii_tx_en high during reset");
            failures++;
        end

endmodule

bind rmii_port rmii_port_chk chk_i (
    .clock          (clock),
    .arst_n         (arst_n),
    .receive_data   (receive_data),
    .receive_valid  (receive_valid),
    .receive_last   (receive_last),
    .receive_ready  (receive_ready),
    .transmit_data  (transmit_data),
    .transmit_valid (transmit_valid),
    .transmit_last  (transmit_last),
    .transmit_ready (transmit_ready),
    .rmii_tx_en     (rmii_tx_en)
);

// File: rmii_port_tb.sv
`timescale 1ns/100ps

module rmii_port_tb;

    localparam int CLOCK_HALF = 2;
    localparam int RESET_CYCLES = 16;
    localparam int PREAMBLE_BYTES = 7;
    localparam int FRAME_PAYLOAD = 60;
    localparam int SHORT_PAYLOAD = 28;
    localparam int BURST_BYTES = 20;
    localparam int GAP_CYCLES = 12;
    // Seven frames near 300 line cycles each, stalled drains and the burst, with wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    typedef logic [7:0] byte_queue_t [$];

    logic           clock;
    logic           arst_n;
    logic [1:0]     rmii_rxd;
    logic           rmii_crs_dv;
    logic           rmii_rx_er;
    logic [1:0]     rmii_txd;
    logic           rmii_tx_en;
    logic [7:0]     receive_data;
    logic           receive_valid;
    logic           receive_last;
    logic           receive_ready = 1'b1;
    logic [7:0]     transmit_data;
    logic           transmit_valid;
    logic           transmit_last;
    logic           transmit_ready;

    integer         seed = 20;
    int             cycle_count = 0;
    int             tx_rises = 0;
    logic           tx_en_prev = 1'b0;
    logic           stall_enable = 1'b0;
    logic [7:0]     expected_data [$];
    logic           expected_last [$];
    logic [1:0]     expected_dibit [$];

    rmii_port dut_i (
        .clock          (clock),
        .arst_n         (arst_n),
        .rmii_rxd       (rmii_rxd),
        .rmii_crs_dv    (rmii_crs_dv),
        .rmii_rx_er     (rmii_rx_er),
        .rmii_txd       (rmii_txd),
        .rmii_tx_en     (rmii_tx_en),
        .receive_data   (receive_data),
        .receive_valid  (receive_valid),
        .receive_last   (receive_last),
        .receive_ready  (receive_ready),
        .transmit_data  (transmit_data),
        .transmit_valid (transmit_valid),
        .transmit_last  (transmit_last),
        .transmit_ready (transmit_ready)
    );

    initial begin
        clock = 1'b0;
        forever #CLOCK_HALF clock = ~clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
        abort_run($sformatf("ERROR at %0d ns: %s expected 0x%02h, got 0x%02h",
            $time, name, expected, actual));
    endtask

    ////////////////////////////////////////
    // Frame building
    ////////////////////////////////////////

    // Bitwise CRC-32, LSB of each byte first
    function automatic logic [31:0] fcs_of(input byte_queue_t bytes);
        logic [31:0] crc;
        logic feedback;
        crc = frame_pkg::CRC_INIT;
        for (int i = 0; i < bytes.size(); i++) begin
            for (int b = 0; b < 8; b++) begin
                feedback = crc[0] ^ bytes[i][b];
                crc = crc >> 1;
                if (feedback) begin
                    crc = crc ^ frame_pkg::CRC_POLY;
                end
            end
        end
        return ~crc;
    endfunction

    task automatic random_bytes(input int length, output byte_queue_t bytes);
        bytes = {};
        for (int i = 0; i < length; i++) begin
            bytes.push_back(8'($random(seed)));
        end
    endtask

    task automatic append_fcs(inout byte_queue_t frame);
        logic [31:0] fcs;
        fcs = fcs_of(frame);
        for (int k = 0; k < 4; k++) begin
            frame.push_back(fcs[8*k +: 8]);
        end
    endtask

    ////////////////////////////////////////
    // Line and stream drivers
    ////////////////////////////////////////

    // Negative index means no corruption or no receive error
    task automatic send_frame(input byte_queue_t frame, input int corrupt_at, input int error_at);
        byte_queue_t line;
        logic [7:0] value;
        if (corrupt_at < 0 && error_at < 0) begin
            for (int i = 0; i < frame.size(); i++) begin
                expected_data.push_back(frame[i]);
                expected_last.push_back(i == frame.size() - 1);
            end
        end
        for (int i = 0; i < PREAMBLE_BYTES; i++) begin
            line.push_back(8'h55);
        end
        line.push_back(rmii_pkg::SFD_BYTE);
        for (int i = 0; i < frame.size(); i++) begin
            value = frame[i];
            if (i == corrupt_at) begin
                value = value ^ 8'h10;
            end
            line.push_back(value);
        end
        for (int i = 0; i < line.size(); i++) begin
            value = line[i];
            for (int d = 0; d < rmii_pkg::DIBITS_PER_BYTE; d++) begin
                @(negedge clock);
                rmii_crs_dv = 1'b1;
                rmii_rxd = value[2*d +: 2];
                rmii_rx_er = (i == error_at + PREAMBLE_BYTES + 1) && (d == 0);
            end
        end
        @(negedge clock);
        rmii_crs_dv = 1'b0;
        rmii_rxd = 2'b00;
        rmii_rx_er = 1'b0;
        repeat (GAP_CYCLES) @(negedge clock);
    endtask

    task automatic send_burst(input byte_queue_t burst);
        for (int i = 0; i < burst.size(); i++) begin
            @(negedge clock);
            transmit_data = burst[i];
            transmit_valid = 1'b1;
            transmit_last = (i == burst.size() - 1);
            while (!transmit_ready) begin
                @(negedge clock);
            end
        end
        @(negedge clock);
        transmit_valid = 1'b0;
        transmit_last = 1'b0;
    endtask

    task automatic wait_delivered();
        while (expected_data.size() != 0) begin
            @(negedge clock);
        end
    endtask

    ////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////

    always @(negedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the tests did not finish within the cycle limit");
        end
        if (dut_i.chk_i.failures != 0) begin
            abort_run("A bound handshake or reset assertion failed");
        end
    end

    // Ready is set first, so a transfer seen here happens on the next rising edge
    always @(negedge clock) begin : receive_monitor
        logic [31:0] r;
        if (stall_enable) begin
            r = $random(seed);
            receive_ready = (r[1:0] != 2'b00);
        end else begin
            receive_ready = 1'b1;
        end
        if (arst_n && receive_valid && receive_ready) begin
            assert (expected_data.size() > 0)
                else abort_run("Receive stream delivered a byte that no good frame explains");
            assert (receive_data == expected_data[0])
                else report_mismatch("receive_data", expected_data[0], receive_data);
            assert (receive_last == expected_last[0])
                else report_mismatch("receive_last", {7'b0, expected_last[0]},
                    {7'b0, receive_last});
            void'(expected_data.pop_front());
            void'(expected_last.pop_front());
        end
    end

    always @(negedge clock) begin
        if (rmii_tx_en) begin
            if (!tx_en_prev) begin
                tx_rises++;
            end
            assert (expected_dibit.size() > 0)
                else abort_run("rmii_tx_en was high outside the transmit burst");
            assert (rmii_txd == expected_dibit[0])
                else report_mismatch("rmii_txd", {6'b0, expected_dibit[0]}, {6'b0, rmii_txd});
            void'(expected_dibit.pop_front());
        end
        tx_en_prev = rmii_tx_en;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin : stimulus
        byte_queue_t frame_a;
        byte_queue_t frame_b;
        byte_queue_t burst;
        logic [7:0] value;
        arst_n = 1'b1;
        rmii_rxd = 2'b00;
        rmii_crs_dv = 1'b0;
        rmii_rx_er = 1'b0;
        transmit_data = 8'h00;
        transmit_valid = 1'b0;
        transmit_last = 1'b0;
        @(negedge clock);
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        arst_n = 1'b1;
        repeat (4) @(negedge clock);

        // One good frame
        random_bytes(FRAME_PAYLOAD, frame_a);
        append_fcs(frame_a);
        send_frame(frame_a, -1, -1);
        wait_delivered();

        // Corrupted payload byte, then a good frame
        random_bytes(FRAME_PAYLOAD, frame_a);
        append_fcs(frame_a);
        random_bytes(FRAME_PAYLOAD, frame_b);
        append_fcs(frame_b);
        send_frame(frame_a, 17, -1);
        send_frame(frame_b, -1, -1);
        wait_delivered();

        // Receive error mid-frame, then a short good frame
        random_bytes(FRAME_PAYLOAD, frame_a);
        append_fcs(frame_a);
        random_bytes(SHORT_PAYLOAD, frame_b);
        append_fcs(frame_b);
        send_frame(frame_a, -1, 30);
        send_frame(frame_b, -1, -1);
        wait_delivered();

        // Back to back under random stalls
        random_bytes(FRAME_PAYLOAD, frame_a);
        append_fcs(frame_a);
        random_bytes(FRAME_PAYLOAD, frame_b);
        append_fcs(frame_b);
        @(posedge clock);
        stall_enable = 1'b1;
        send_frame(frame_a, -1, -1);
        send_frame(frame_b, -1, -1);
        wait_delivered();
        @(posedge clock);
        stall_enable = 1'b0;

        // Transmit burst, low dibit first
        random_bytes(BURST_BYTES, burst);
        for (int i = 0; i < burst.size(); i++) begin
            value = burst[i];
            for (int d = 0; d < rmii_pkg::DIBITS_PER_BYTE; d++) begin
                expected_dibit.push_back(value[2*d +: 2]);
            end
        end
        send_burst(burst);
        while (expected_dibit.size() != 0 || rmii_tx_en) begin
            @(negedge clock);
        end
        assert (tx_rises == 1)
            else abort_run("rmii_tx_en did not stay high as one unbroken burst");

        if (dut_i.chk_i.failures == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run("A bound handshake or reset assertion failed");
        end
    end

endmodule

// File: flist.f
rmii_pkg.sv
frame_pkg.sv
rmii_byte_packager.sv
synchronous_fifo.sv
ethernet_packet_parser.sv
receive_slot_handler.sv
rmii_byte_shipper.sv
rmii_port.sv
rmii_port_chk.sv
rmii_port_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the RMII port testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f flist.f --top-module rmii_port_tb -o rmii_port_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rmii_port_sim +verilator+error+limit+100 2>&1)
sim_status=$?
echo "$output"

if [ $sim_status -ne 0 ]; then
    exit 1
fi
if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
